// ==== Makefile ====
# Verilator build for the line buffer to DRAM mover testbench.

VERILATOR ?= verilator
TOP       := tb_hyper_mover
DUT_TOP   := hyper_mover_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing -Wall
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/dram_column_store.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Column store: word array with byte-enabled writes and a
// registered test read port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dram_column_store (
	input wire logic CLK,
	input wire logic RST,
	input wire logic wr_request,
	input wire logic [hyper_pkg::COL_W-1:0] wr_column,
	input wire logic [hyper_pkg::WORD_W-1:0] wr_data,
	input wire logic [hyper_pkg::BE_W-1:0] wr_enables,
	input wire logic [hyper_pkg::COL_W-1:0] rd_column,
	output logic [hyper_pkg::WORD_W-1:0] rd_data
);

	logic [hyper_pkg::WORD_W-1:0] mem [2**hyper_pkg::COL_W];

	// Only bytes with their enable set are written.
	always_ff @(posedge CLK)
	begin
		if (wr_request)
		begin
			for (int b = 0; b < hyper_pkg::BE_W; b++)
			begin
				if (wr_enables[b])
					mem[wr_column][b*8 +: 8] <= wr_data[b*8 +: 8];
			end
		end
	end

	// Observation port, one cycle after the address.
	always_ff @(posedge CLK)
	begin
		if (!RST)
			rd_data <= '0;
		else
			rd_data <= mem[rd_column];
	end

endmodule

`default_nettype wire

// ==== rtl/dram_word_packer.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word packer: pairs halfwords into DRAM words with byte
// enables and raises one write request per word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dram_word_packer (
	input wire logic CLK,
	input wire logic RST,
	input wire logic [hyper_pkg::HALF_W-1:0] half_data,
	input wire logic [hyper_pkg::ADDR_W-1:0] half_address,
	input wire logic half_valid,
	input wire logic half_last,
	output logic wr_request,
	output logic [hyper_pkg::COL_W-1:0] wr_column,
	output logic [hyper_pkg::WORD_W-1:0] wr_data,
	output logic [hyper_pkg::BE_W-1:0] wr_enables
);

	// Set while the low half of wr_data holds a halfword not yet written.
	logic lo_pend;
	logic is_high;

	assign is_high = half_address[0];

	// Request and pending flag.
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			wr_request <= 1'b0;
			lo_pend <= 1'b0;
		end
		else
		begin
			wr_request <= 1'b0;
			if (half_valid)
			begin
				if (is_high)
				begin
					wr_request <= 1'b1;
					lo_pend <= 1'b0;
				end
				else
				begin
					// A trailing even halfword goes out on its own.
					wr_request <= half_last;
					lo_pend <= ~half_last;
				end
			end
		end
	end

	// The outgoing word doubles as the holding word.
	always_ff @(posedge CLK)
	begin
		if (half_valid)
		begin
			wr_column <= half_address[hyper_pkg::ADDR_W-1:1];
			if (is_high)
			begin
				wr_data <= {half_data, wr_data[hyper_pkg::HALF_W-1:0]};
				wr_enables <= {{(hyper_pkg::BE_W/2){1'b1}},
					{(hyper_pkg::BE_W/2){lo_pend}}};
			end
			else
			begin
				wr_data <= {{hyper_pkg::HALF_W{1'b0}}, half_data};
				wr_enables <= {{(hyper_pkg::BE_W/2){1'b0}},
					{(hyper_pkg::BE_W/2){1'b1}}};
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/hyper_mover_top.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mover subsystem: line buffer, block mover, word packer and
// column store chained as one pipeline.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hyper_mover_top (
	input wire logic CLK,
	input wire logic RST,
	input wire logic lsab_wr,
	input wire logic [hyper_pkg::SECT_W-1:0] lsab_wr_section,
	input wire logic [hyper_pkg::HALF_W-1:0] lsab_wr_data,
	input wire logic [hyper_pkg::ADDR_W-1:0] start_address,
	input wire logic [hyper_pkg::COUNT_W-1:0] count,
	input wire logic [hyper_pkg::SECT_W-1:0] section,
	input wire logic issue,
	input wire logic [hyper_pkg::COL_W-1:0] rd_column,
	output logic working,
	output logic [hyper_pkg::COUNT_W-1:0] count_sent,
	output logic done,
	output logic [hyper_pkg::WORD_W-1:0] rd_data
);

	// Buffer to mover.
	logic [hyper_pkg::NUM_SECT-1:0] empty_flags;
	logic [hyper_pkg::HALF_W-1:0] head_data;
	logic pop;
	logic [hyper_pkg::SECT_W-1:0] pop_section;

	// Mover to packer.
	logic [hyper_pkg::HALF_W-1:0] half_data;
	logic [hyper_pkg::ADDR_W-1:0] half_address;
	logic half_valid;
	logic half_last;

	// Packer to store.
	logic wr_request;
	logic [hyper_pkg::COL_W-1:0] wr_column;
	logic [hyper_pkg::WORD_W-1:0] wr_data;
	logic [hyper_pkg::BE_W-1:0] wr_enables;

	lsab_sections u_lsab (
		.CLK(CLK),
		.RST(RST),
		.wr(lsab_wr),
		.wr_section(lsab_wr_section),
		.wr_data(lsab_wr_data),
		.pop(pop),
		.pop_section(pop_section),
		.empty_flags(empty_flags),
		.head_data(head_data)
	);

	hyper_mvblck_todram u_mover (
		.CLK(CLK),
		.RST(RST),
		.start_address(start_address),
		.count(count),
		.section(section),
		.issue(issue),
		.empty_flags(empty_flags),
		.head_data(head_data),
		.pop(pop),
		.pop_section(pop_section),
		.half_data(half_data),
		.half_address(half_address),
		.half_valid(half_valid),
		.half_last(half_last),
		.working(working),
		.count_sent(count_sent),
		.done(done)
	);

	dram_word_packer u_packer (
		.CLK(CLK),
		.RST(RST),
		.half_data(half_data),
		.half_address(half_address),
		.half_valid(half_valid),
		.half_last(half_last),
		.wr_request(wr_request),
		.wr_column(wr_column),
		.wr_data(wr_data),
		.wr_enables(wr_enables)
	);

	dram_column_store u_store (
		.CLK(CLK),
		.RST(RST),
		.wr_request(wr_request),
		.wr_column(wr_column),
		.wr_data(wr_data),
		.wr_enables(wr_enables),
		.rd_column(rd_column),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// ==== rtl/hyper_mvblck_todram.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block mover: pops halfwords from one line buffer section and
// hands them on with their DRAM halfword address.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hyper_mvblck_todram (
	input wire logic CLK,
	input wire logic RST,
	input wire logic [hyper_pkg::ADDR_W-1:0] start_address,
	input wire logic [hyper_pkg::COUNT_W-1:0] count,
	input wire logic [hyper_pkg::SECT_W-1:0] section,
	input wire logic issue,
	input wire logic [hyper_pkg::NUM_SECT-1:0] empty_flags,
	input wire logic [hyper_pkg::HALF_W-1:0] head_data,
	output logic pop,
	output logic [hyper_pkg::SECT_W-1:0] pop_section,
	output logic [hyper_pkg::HALF_W-1:0] half_data,
	output logic [hyper_pkg::ADDR_W-1:0] half_address,
	output logic half_valid,
	output logic half_last,
	output logic working,
	output logic [hyper_pkg::COUNT_W-1:0] count_sent,
	output logic done
);

	// Move state, latched on an accepted issue.
	logic busy;
	logic [hyper_pkg::SECT_W-1:0] sect_q;
	logic [hyper_pkg::ADDR_W-1:0] addr_q;
	logic [hyper_pkg::COUNT_W-1:0] count_q;
	logic [hyper_pkg::COUNT_W-1:0] sent_q;

	logic sel_empty;
	logic pop_ok;
	logic end_move;

	// First delay stage between the end of a move and done.
	logic end_d1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pop decision
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign sel_empty = empty_flags[sect_q];

	// One pop per cycle while data remains and the count is not reached.
	assign pop_ok = busy && !sel_empty && (sent_q < count_q);

	// The first busy cycle without a pop ends the move.
	assign end_move = busy && !pop_ok;

	assign pop = pop_ok;
	assign pop_section = sect_q;

	// The halfword on the output is the final one when no pop follows it.
	// This covers both a reached count and a section running dry.
	assign half_last = half_valid && !pop_ok;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			busy <= 1'b0;
			sect_q <= '0;
			addr_q <= '0;
			count_q <= '0;
			sent_q <= '0;
			count_sent <= '0;
			half_valid <= 1'b0;
			end_d1 <= 1'b0;
			done <= 1'b0;
			working <= 1'b0;
		end
		else
		begin
			half_valid <= pop_ok;

			// Done trails the end of the move by two registers.
			end_d1 <= end_move;
			done <= end_d1;

			if (!working && issue)
			begin
				busy <= 1'b1;
				working <= 1'b1;
				sect_q <= section;
				addr_q <= start_address;
				count_q <= count;
				sent_q <= '0;
			end
			else if (busy)
			begin
				if (pop_ok)
				begin
					addr_q <= addr_q + 1'b1;
					sent_q <= sent_q + 1'b1;
				end
				else
				begin
					busy <= 1'b0;
					count_sent <= sent_q;
				end
			end

			// Working drops together with the rise of done.
			if (end_d1)
				working <= 1'b0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Halfword payload
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Capture the head entry at the same edge that removes it.
	always_ff @(posedge CLK)
	begin
		if (pop_ok)
		begin
			half_data <= head_data;
			half_address <= addr_q;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/hyper_pkg.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths and limits for the line buffer to DRAM mover.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package hyper_pkg;

	// Data path widths.
	localparam int HALF_W = 16;
	localparam int WORD_W = 32;
	localparam int BE_W = 4;

	// A halfword address carries the half select in bit 0.
	// The word (column) address is the remaining upper bits.
	localparam int ADDR_W = 12;
	localparam int COL_W = 11;

	// A single move never exceeds this many halfwords.
	localparam int MAX_BLOCK = 24;
	localparam int COUNT_W = 5;

	// Line buffer geometry.
	localparam int NUM_SECT = 4;
	localparam int SECT_W = 2;
	localparam int LSAB_DEPTH = 32;
	localparam int LSAB_PTR_W = 5;

endpackage

`default_nettype wire

// ==== rtl/lsab_sections.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line buffer with four show-ahead halfword FIFOs.
// One shared write port, one pop port that picks a section.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsab_sections (
	input wire logic CLK,
	input wire logic RST,
	input wire logic wr,
	input wire logic [hyper_pkg::SECT_W-1:0] wr_section,
	input wire logic [hyper_pkg::HALF_W-1:0] wr_data,
	input wire logic pop,
	input wire logic [hyper_pkg::SECT_W-1:0] pop_section,
	output logic [hyper_pkg::NUM_SECT-1:0] empty_flags,
	output logic [hyper_pkg::HALF_W-1:0] head_data
);

	// Storage for all sections, indexed by section then entry.
	logic [hyper_pkg::HALF_W-1:0] mem [hyper_pkg::NUM_SECT][hyper_pkg::LSAB_DEPTH];

	// Per-section pointers and occupancy.
	// Occupancy is one bit wider than a pointer so that full is visible.
	logic [hyper_pkg::LSAB_PTR_W-1:0] rd_ptr [hyper_pkg::NUM_SECT];
	logic [hyper_pkg::LSAB_PTR_W-1:0] wr_ptr [hyper_pkg::NUM_SECT];
	logic [hyper_pkg::LSAB_PTR_W:0] occ [hyper_pkg::NUM_SECT];

	logic [hyper_pkg::NUM_SECT-1:0] push_en;
	logic [hyper_pkg::NUM_SECT-1:0] pop_en;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Section decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A push into a full section is dropped here.
	// A pop from an empty section is ignored as well.
	always_comb
	begin
		for (int s = 0; s < hyper_pkg::NUM_SECT; s++)
		begin
			empty_flags[s] = (occ[s] == '0);
			push_en[s] = wr && (int'(wr_section) == s) &&
				(occ[s] != (hyper_pkg::LSAB_PTR_W+1)'(hyper_pkg::LSAB_DEPTH));
			pop_en[s] = pop && (int'(pop_section) == s) && (occ[s] != '0);
		end
	end

	// Show-ahead: the oldest entry of the selected section.
	assign head_data = mem[pop_section][rd_ptr[pop_section]];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointer and occupancy update
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			for (int s = 0; s < hyper_pkg::NUM_SECT; s++)
			begin
				rd_ptr[s] <= '0;
				wr_ptr[s] <= '0;
				occ[s] <= '0;
			end
		end
		else
		begin
			for (int s = 0; s < hyper_pkg::NUM_SECT; s++)
			begin
				// Pointers wrap on their own since the depth is a power of two.
				if (push_en[s])
					wr_ptr[s] <= wr_ptr[s] + 1'b1;
				if (pop_en[s])
					rd_ptr[s] <= rd_ptr[s] + 1'b1;

				// A push and a pop in the same cycle leave occupancy as it is.
				case ({push_en[s], pop_en[s]})
					2'b10: occ[s] <= occ[s] + 1'b1;
					2'b01: occ[s] <= occ[s] - 1'b1;
					default: occ[s] <= occ[s];
				endcase
			end
		end
	end

	// The entry array itself.
	always_ff @(posedge CLK)
	begin
		if (push_en[wr_section])
			mem[wr_section][wr_ptr[wr_section]] <= wr_data;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/hyper_pkg.sv
rtl/lsab_sections.sv
rtl/hyper_mvblck_todram.sv
rtl/dram_word_packer.sv
rtl/dram_column_store.sv
rtl/hyper_mover_top.sv
sim/tb_hyper_mover.sv

// ==== sim/tb_hyper_mover.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the mover subsystem. A model of the
// buffer sections and of the column store predicts every result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_hyper_mover;

	localparam int NUM_RANDOM = 40;
	localparam int NUM_TESTS = 7 + NUM_RANDOM;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (hyper_pkg::MAX_BLOCK + 64);

	logic CLK;
	logic RST;
	logic lsab_wr;
	logic [hyper_pkg::SECT_W-1:0] lsab_wr_section;
	logic [hyper_pkg::HALF_W-1:0] lsab_wr_data;
	logic [hyper_pkg::ADDR_W-1:0] start_address;
	logic [hyper_pkg::COUNT_W-1:0] count;
	logic [hyper_pkg::SECT_W-1:0] section;
	logic issue;
	logic [hyper_pkg::COL_W-1:0] rd_column;
	logic working;
	logic [hyper_pkg::COUNT_W-1:0] count_sent;
	logic done;
	logic [hyper_pkg::WORD_W-1:0] rd_data;

	int errors;
	logic [31:0] rng;

	// Reference model. Known flags mark halves that a move has written.
	logic [hyper_pkg::HALF_W-1:0] model_sect [hyper_pkg::NUM_SECT][$];
	logic [hyper_pkg::WORD_W-1:0] ref_mem [2**hyper_pkg::COL_W];
	logic [1:0] known [2**hyper_pkg::COL_W];

	hyper_mover_top dut0 (
		.CLK(CLK),
		.RST(RST),
		.lsab_wr(lsab_wr),
		.lsab_wr_section(lsab_wr_section),
		.lsab_wr_data(lsab_wr_data),
		.start_address(start_address),
		.count(count),
		.section(section),
		.issue(issue),
		.rd_column(rd_column),
		.working(working),
		.count_sent(count_sent),
		.done(done),
		.rd_data(rd_data)
	);

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act == exp)
		else
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Pushes n random halfwords into one section, one per cycle.
	task automatic load_section(input logic [1:0] sect, input int n);
		for (int i = 0; i < n; i++)
		begin
			@(negedge CLK);
			rng = next_random(rng);
			lsab_wr = 1'b1;
			lsab_wr_section = sect;
			lsab_wr_data = rng[15:0];
			if (model_sect[sect].size() < hyper_pkg::LSAB_DEPTH)
				model_sect[sect].push_back(rng[15:0]);
		end
		@(negedge CLK);
		lsab_wr = 1'b0;
	endtask

	// The read port answers one cycle after the column is presented.
	task automatic read_and_compare(input string name, input logic [10:0] col);
		logic [31:0] mask;
		@(negedge CLK);
		rd_column = col;
		@(negedge CLK);
		mask = {{16{known[col][1]}}, {16{known[col][0]}}};
		assert (((rd_data ^ ref_mem[col]) & mask) == 32'h0)
		else
		begin
			$display("[ERROR] %s: column %h expected %h, actual %h", name, col,
				ref_mem[col] & mask, rd_data);
			errors++;
		end
	endtask

	// Reads every column a move could touch plus one on each side.
	task automatic check_columns(input string name, input logic [11:0] addr, input int n);
		logic [11:0] a_last;
		logic [10:0] diff;
		logic [10:0] c;
		a_last = addr + 12'((n > 0) ? n - 1 : 0);
		diff = a_last[11:1] - addr[11:1];
		c = addr[11:1] - 11'd1;
		for (int i = 0; i < int'(diff) + 3; i++)
		begin
			read_and_compare(name, c);
			c = c + 11'd1;
		end
	endtask

	task automatic run_move(input string name, input logic [1:0] sect,
		input logic [11:0] addr, input logic [4:0] cnt);
		int exp_n;
		logic [11:0] a;
		exp_n = (int'(cnt) < model_sect[sect].size()) ? int'(cnt) : model_sect[sect].size();
		@(negedge CLK);
		start_address = addr;
		count = cnt;
		section = sect;
		issue = 1'b1;
		@(negedge CLK);
		issue = 1'b0;
		check_equal({name, " working"}, 32'h1, 32'(working));
		while (!done)
			@(negedge CLK);
		check_equal(name, 32'(exp_n), 32'(count_sent));

		// Done is a single-cycle pulse.
		@(negedge CLK);
		check_equal({name, " done pulse"}, 32'h0, 32'(done));

		// Bit 0 of the halfword address picks the half of the word.
		for (int i = 0; i < exp_n; i++)
		begin
			a = addr + 12'(i);
			if (a[0])
				ref_mem[a[11:1]][31:16] = model_sect[sect].pop_front();
			else
				ref_mem[a[11:1]][15:0] = model_sect[sect].pop_front();
			known[a[11:1]][a[0]] = 1'b1;
		end
		check_columns(name, addr, exp_n);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_after_reset();
		@(negedge CLK);
		check_equal("after_reset working", 32'h0, 32'(working));
		check_equal("after_reset done", 32'h0, 32'(done));
		check_equal("after_reset count_sent", 32'h0, 32'(count_sent));
	endtask

	// Aims at the aligned block so that any stray write would show.
	task automatic test_empty_section();
		run_move("empty_section", 2'd3, 12'h104, 5'd5);
	endtask

	task automatic test_aligned_block();
		load_section(2'd0, 24);
		run_move("aligned_block", 2'd0, 12'h100, 5'd24);
	endtask

	// Overlaps the aligned block, so the kept halves hold real data.
	task automatic test_odd_edges();
		load_section(2'd1, 6);
		run_move("odd_edges", 2'd1, 12'h103, 5'd6);
	endtask

	task automatic test_early_end();
		load_section(2'd2, 5);
		run_move("early_end", 2'd2, 12'h2a0, 5'd20);
	endtask

	// First round leaves 1 + s entries behind, second round drains them.
	task automatic test_all_sections();
		for (int s = 0; s < hyper_pkg::NUM_SECT; s++)
			load_section(2'(s), 5 + s);
		for (int s = 0; s < hyper_pkg::NUM_SECT; s++)
			run_move("all_sections", 2'(s), 12'(12'h300 + 32 * s), 5'd4);
		for (int s = 0; s < hyper_pkg::NUM_SECT; s++)
			run_move("all_sections_rest", 2'(s), 12'(12'h381 + 32 * s), 5'd8);
	endtask

	task automatic test_random_moves();
		logic [1:0] sect;
		logic [11:0] addr;
		logic [4:0] cnt;
		int fill;
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			rng = next_random(rng);
			sect = rng[1:0];
			rng = next_random(rng);
			addr = rng[11:0];
			rng = next_random(rng);
			cnt = 5'(1 + rng % 24);
			rng = next_random(rng);
			fill = int'(rng % 32'(hyper_pkg::LSAB_DEPTH + 1 - model_sect[sect].size()));
			load_section(sect, fill);
			run_move("random", sect, addr, cnt);
		end
	endtask

	initial
	begin
		errors = 0;
		rng = 32'hcede;
		RST = 1'b0;
		lsab_wr = 1'b0;
		lsab_wr_section = '0;
		lsab_wr_data = '0;
		start_address = '0;
		count = '0;
		section = '0;
		issue = 1'b0;
		rd_column = '0;
		for (int c = 0; c < 2**hyper_pkg::COL_W; c++)
		begin
			ref_mem[c] = '0;
			known[c] = 2'b00;
		end
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b1;

		test_after_reset();
		test_aligned_block();
		test_empty_section();
		test_odd_edges();
		test_early_end();
		test_all_sections();
		test_random_moves();

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog against a done pulse that never comes.
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
